//--- Makefile
# Verilator flow for the memory stage testbench
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_STR  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_STR)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+src
src/mem_pkg.sv
src/mem_ctrl.sv
src/dcache_ctrl.sv
src/dcache_ram.sv
src/mem_reg.sv
src/mem_stage.sv
dv/l2_mem_model.sv
dv/mem_stage_tb.sv

//--- dv/l2_mem_model.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module l2_mem_model #(
    parameter int MIN_DELAY = 1,                    // response delay window, in cycles
    parameter int MAX_DELAY = 1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               drq,
    input  logic               l2_cache_rw,         // 1 = write back
    input  logic [`WORD_W-1:0] l2_addr,
    input  logic [`LINE_W-1:0] l2_wr_line,
    output logic [`LINE_W-1:0] l2_rd_line,
    output logic               l2_rdy
);

    logic [`LINE_W-1:0] mem [logic [`WORD_W-1:0]];  // only lines written back so far
    logic               busy;
    int                 wait_cnt;
    int                 wb_count;                   // write-backs seen
    logic [`WORD_W-1:0] last_wb_addr;
    logic [`LINE_W-1:0] last_wb_line;

    // fold of all address bytes, so every address bit matters
    function automatic logic [7:0] fill_byte(input logic [`WORD_W-1:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
    endfunction

    function automatic logic [`LINE_W-1:0] fill_line(input logic [`WORD_W-1:0] a);
        logic [`LINE_W-1:0] l;
        for (int b = 0; b < `LINE_W / 8; b++) begin
            l[b*8 +: 8] = fill_byte(a + 32'(b));    // byte 0 in the low bits
        end
        return l;
    endfunction

    initial begin
        l2_rdy     = 1'b0;
        l2_rd_line = '0;
        busy       = 1'b0;
        wait_cnt   = 0;
        wb_count   = 0;
    end

    always @(posedge clk) begin
        l2_rdy <= 1'b0;                             // single-cycle pulse
        if (!rst_n) begin
            busy     <= 1'b0;
            wait_cnt <= 0;
        end else if (busy) begin
            if (wait_cnt == 0) begin
                busy   <= 1'b0;
                l2_rdy <= 1'b1;
                if (l2_cache_rw) begin
                    mem[l2_addr] = l2_wr_line;
                    wb_count     = wb_count + 1;
                    last_wb_addr = l2_addr;
                    last_wb_line = l2_wr_line;
                end else begin
                    l2_rd_line <= mem.exists(l2_addr) ? mem[l2_addr] : fill_line(l2_addr);
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (drq && !l2_rdy) begin          // drq still high in the rdy cycle
            busy     <= 1'b1;
            wait_cnt <= $urandom_range(MAX_DELAY - 1, MIN_DELAY - 1);
        end
    end

endmodule

//--- dv/mem_stage_tb.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem_stage_tb import mem_pkg::*; ();

    localparam int L2_MIN_DELAY = 1;                // l2 answer window in cycles
    localparam int L2_MAX_DELAY = 6;
    localparam int N_RANDOM     = 300;
    localparam int TIMEOUT_CYC  = 200;              // per op, covers write-back plus refill

    logic               clk;
    logic               rst_n;
    logic               stall;
    logic               flush;
    ex_mem_t            ex_in;
    logic [`WORD_W-1:0] fwd_data;
    logic               miss_stall;
    mem_wb_t            wb_out;
    logic               drq;
    logic               l2_cache_rw;
    logic [`WORD_W-1:0] l2_addr;
    logic [`LINE_W-1:0] l2_wr_line;
    logic [`LINE_W-1:0] l2_rd_line;
    logic               l2_rdy;

    logic [7:0] shadow [logic [`WORD_W-1:0]];       // stored bytes only
    mem_wb_t    exp_q[$];
    ex_mem_t    idle_op;
    int         n_checks;
    int         n_errors;
    logic       op_missed;                          // miss_stall seen during last op
    logic       op_drq;                             // drq seen during last op
    logic       timed_out;                          // a miss never finished

    mem_stage u_mem_stage (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .ex_in(ex_in),
        .fwd_data(fwd_data), .miss_stall(miss_stall), .wb_out(wb_out), .drq(drq),
        .l2_cache_rw(l2_cache_rw), .l2_addr(l2_addr), .l2_wr_line(l2_wr_line),
        .l2_rd_line(l2_rd_line), .l2_rdy(l2_rdy)
    );

    l2_mem_model #(.MIN_DELAY(L2_MIN_DELAY), .MAX_DELAY(L2_MAX_DELAY)) u_l2 (
        .clk(clk), .rst_n(rst_n), .drq(drq), .l2_cache_rw(l2_cache_rw), .l2_addr(l2_addr),
        .l2_wr_line(l2_wr_line), .l2_rd_line(l2_rd_line), .l2_rdy(l2_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                     // 40 ns period
    end

    // same fold as the l2 backing store
    function automatic logic [7:0] fill_byte(input logic [`WORD_W-1:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
    endfunction

    function automatic logic [7:0] shadow_byte(input logic [`WORD_W-1:0] a);
        return shadow.exists(a) ? shadow[a] : fill_byte(a);
    endfunction

    function automatic logic [`LINE_W-1:0] shadow_line(input logic [`WORD_W-1:0] a);
        logic [`LINE_W-1:0] l;
        for (int b = 0; b < `LINE_W / 8; b++) begin
            l[b*8 +: 8] = shadow_byte(a + 32'(b));
        end
        return l;
    endfunction

    function automatic ex_mem_t make_op(input mem_op_e op, input logic [`WORD_W-1:0] a,
                                        input logic [`WORD_W-1:0] d,
                                        input logic [`REG_ADDR_W-1:0] dst);
        ex_mem_t e;
        e.en       = 1'b1;
        e.mem_op   = op;
        e.wr_data  = d;
        e.dst_addr = dst;
        e.gpr_we_  = (op == MEM_OP_STW) || (op == MEM_OP_STB);  // stores write no gpr
        e.ex_out   = a;
        return e;
    endfunction

    // expected MEM/WB contents straight from the op rules and the shadow memory
    function automatic mem_wb_t ref_wb(input ex_mem_t op);
        mem_wb_t            e;
        logic [`WORD_W-1:0] a;
        logic [`WORD_W-1:0] base;
        logic               bad;
        a    = op.ex_out;
        base = {a[31:2], 2'b00};
        bad  = op.en && (op.mem_op == MEM_OP_LDW || op.mem_op == MEM_OP_STW) && a[1:0] != 0;
        e.en         = op.en;
        e.dst_addr   = op.dst_addr;
        e.gpr_we_    = op.gpr_we_ | bad;
        e.miss_align = bad;
        if (bad) begin
            e.out = '0;
        end else if (op.mem_op == MEM_OP_LDW) begin
            e.out = {shadow_byte(base + 3), shadow_byte(base + 2),
                     shadow_byte(base + 1), shadow_byte(base)};
        end else if (op.mem_op == MEM_OP_LDBU) begin
            e.out = {24'h0, shadow_byte(a)};
        end else begin
            e.out = op.ex_out;
        end
        return e;
    endfunction

    function automatic void store_shadow(input ex_mem_t op);
        logic [`WORD_W-1:0] a;
        a = op.ex_out;
        if (op.en && op.mem_op == MEM_OP_STW && a[1:0] == 2'b00) begin
            for (int b = 0; b < 4; b++) begin
                shadow[a + 32'(b)] = op.wr_data[b*8 +: 8];
            end
        end else if (op.en && op.mem_op == MEM_OP_STB) begin
            shadow[a] = op.wr_data[7:0];
        end
    endfunction

    task automatic check_wb(input string name, input mem_wb_t got, input mem_wb_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_line(input string name, input logic [`LINE_W-1:0] got,
                              input logic [`LINE_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_word(input string name, input logic [`WORD_W-1:0] got,
                              input logic [`WORD_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    // present one op, ride out any miss, queue the expected wb_out for the comparer
    task automatic run_op(input ex_mem_t op);
        mem_wb_t exp_v;
        int      cyc;
        exp_v     = ref_wb(op);
        store_shadow(op);
        op_missed = 1'b0;
        op_drq    = 1'b0;
        cyc       = 0;
        if (!timed_out) begin                       // stuck DUT, skip the rest
            @(posedge clk);
            ex_in <= op;
            @(negedge clk);
            while (miss_stall && !timed_out) begin
                op_missed = 1'b1;
                op_drq    = op_drq | drq;
                cyc++;
                if (cyc > TIMEOUT_CYC) begin
                    $display("timeout: miss_stall high for %0d cycles at %0t", cyc, $time);
                    timed_out = 1'b1;
                end else begin
                    @(negedge clk);
                end
            end
            if (!timed_out) begin
                op_drq = op_drq | drq;
                @(posedge clk);                     // MEM/WB captures here
                ex_in <= idle_op;
                exp_q.push_back(exp_v);
                @(negedge clk);
                #1;
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        $display("test %0d %s: %0d errors", num, name, n_errors - err_before);
    endtask

    always @(negedge clk) begin
        if (exp_q.size() > 0) begin
            check_wb("wb_out", wb_out, exp_q.pop_front());
        end
    end

    initial begin : stimulus
        int                 err0;
        int                 wb_before;
        int                 kind;
        mem_op_e            rop;
        logic [1:0]         tsel;
        logic [1:0]         idx;
        logic [1:0]         woff;
        logic [1:0]         boff;
        logic [`WORD_W-1:0] raddr;
        ex_mem_t            op2;
        void'($urandom(45));
        n_checks       = 0;
        n_errors       = 0;
        timed_out      = 1'b0;
        idle_op        = '0;
        idle_op.gpr_we_ = 1'b1;
        ex_in          = idle_op;
        stall          = 1'b0;
        flush          = 1'b0;
        rst_n          = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        err0 = n_errors;                            // cold miss then hit
        run_op(make_op(MEM_OP_LDW, 32'h0000_1004, '0, 5'd1));
        check_bit("miss_stall", op_missed, 1'b1);
        run_op(make_op(MEM_OP_LDW, 32'h0000_1004, '0, 5'd2));
        check_bit("miss_stall", op_missed, 1'b0);
        report_test(1, "cold miss", err0);

        err0 = n_errors;
        run_op(make_op(MEM_OP_STW, 32'h0000_1008, 32'hdead_beef, 5'd0));
        run_op(make_op(MEM_OP_LDW, 32'h0000_1008, '0, 5'd3));
        run_op(make_op(MEM_OP_STB, 32'h0000_1009, 32'h0000_00a5, 5'd0));
        run_op(make_op(MEM_OP_LDBU, 32'h0000_1009, '0, 5'd4));
        run_op(make_op(MEM_OP_LDW, 32'h0000_1008, '0, 5'd4));
        report_test(2, "store then load", err0);

        err0      = n_errors;                       // three tags on index 1
        wb_before = u_l2.wb_count;
        run_op(make_op(MEM_OP_STW, 32'h0000_2010, 32'h1111_aaaa, 5'd0));
        run_op(make_op(MEM_OP_STW, 32'h0001_2010, 32'h2222_bbbb, 5'd0));
        run_op(make_op(MEM_OP_STW, 32'h0002_2014, 32'h3333_cccc, 5'd0));
        check_word("l2 write-back count", u_l2.wb_count, wb_before + 1);
        check_word("l2_addr", u_l2.last_wb_addr, 32'h0000_2010);
        check_line("l2_wr_line", u_l2.last_wb_line, shadow_line(32'h0000_2010));
        run_op(make_op(MEM_OP_LDW, 32'h0000_2010, '0, 5'd5));
        report_test(3, "dirty eviction", err0);

        err0 = n_errors;                            // line 0x3000 not cached yet
        run_op(make_op(MEM_OP_LDW, 32'h0000_3002, '0, 5'd6));
        check_bit("drq", op_drq, 1'b0);
        run_op(make_op(MEM_OP_STW, 32'h0000_300a, 32'hbad0_bad0, 5'd0));
        check_bit("drq", op_drq, 1'b0);
        run_op(make_op(MEM_OP_LDW, 32'h0000_3008, '0, 5'd6));   // memory untouched
        report_test(4, "misaligned", err0);

        err0 = n_errors;
        run_op(make_op(MEM_OP_NOP, 32'h1234_5678, '0, 5'd7));
        op2 = make_op(MEM_OP_NOP, 32'h0bad_cafe, '0, 5'd8);
        @(posedge clk);
        ex_in <= op2;
        @(negedge clk);
        check_word("fwd_data", fwd_data, op2.ex_out);
        @(posedge clk);                             // op2 captured
        flush <= 1'b1;
        @(posedge clk);                             // flush takes effect
        flush <= 1'b0;
        ex_in <= idle_op;
        @(negedge clk);
        check_bit("wb_out.en", wb_out.en, 1'b0);
        @(posedge clk);                             // bubble captured, then hold
        stall <= 1'b1;
        ex_in <= op2;
        repeat (3) begin
            @(negedge clk);
            check_wb("wb_out", wb_out, ref_wb(idle_op));
        end
        @(posedge clk);
        stall <= 1'b0;
        run_op(op2);
        report_test(5, "non-memory, flush and stall", err0);

        err0 = n_errors;
        for (int i = 0; i < N_RANDOM; i++) begin
            tsel = 2'($urandom_range(2, 0));
            idx  = 2'($urandom_range(3, 0));
            woff = 2'($urandom_range(3, 0));
            boff = 2'($urandom_range(3, 0));
            kind = $urandom_range(4, 0);
            case (kind)
                0:       rop = MEM_OP_NOP;
                1:       rop = MEM_OP_LDW;
                2:       rop = MEM_OP_LDBU;
                3:       rop = MEM_OP_STW;
                default: rop = MEM_OP_STB;
            endcase
            if ((rop == MEM_OP_LDW || rop == MEM_OP_STW) && $urandom_range(3, 0) != 0) begin
                boff = 2'b00;                       // keep most word ops aligned
            end
            raddr = {18'h2, tsel, 6'h00, idx, woff, boff};  // tags 8..10, sets 0..3
            run_op(make_op(rop, raddr, $urandom, 5'($urandom_range(31, 0))));
        end
        report_test(6, "random ops", err0);

        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- src/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath
`define WORD_W      32      // data word, also byte address width
`define REG_ADDR_W  5       // gpr index

// L1 data cache geometry
`define TAG_W       20      // address bits above the index
`define INDEX_W     8       // set select
`define LINE_W      128     // four words per line
`define DC_SETS     256     // 2**INDEX_W

// address split: tag | index | word offset (2) | byte offset (2)
// TAG_W + INDEX_W + 4 must equal WORD_W

`endif

//--- src/dcache_ctrl.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module dcache_ctrl import mem_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  mem_req_t            req,            // from mem_ctrl
    input  dc_rd_t              rd,             // ram contents at rd_index
    input  logic [`LINE_W-1:0]  l2_rd_line,
    input  logic                l2_rdy,         // one-cycle pulse per request
    output logic [`INDEX_W-1:0] rd_index,
    output dc_wr_t              wr,
    output logic [`LINE_W-1:0]  hit_line,
    output logic                miss_stall,
    output logic                drq,
    output logic                l2_cache_rw,    // 1 = write back
    output logic [`WORD_W-1:0]  l2_addr,        // line aligned
    output logic [`LINE_W-1:0]  l2_wr_line
);

    localparam int OFF_W = `WORD_W - `TAG_W - `INDEX_W;

    typedef enum logic [1:0] {IDLE, WRITEBACK, REFILL, FILL_DONE} state_e;

    state_e             state;
    state_e             state_n;
    logic [1:0]         way_hit;
    logic               hit;
    logic               hit_way;
    logic               victim_way;
    logic               victim_q;               // way being replaced
    logic               serve;
    logic               xfer_done;
    logic [`LINE_W-1:0] merged;

    assign rd_index = req.addr.f.index;         // ex_in held during a miss

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = rd.valid[w] && (rd.tag[w] == req.addr.f.tag);
        end
    end

    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];
    assign hit_line   = rd.line[hit_way];
    assign victim_way = !rd.valid[0] ? 1'b0 : (!rd.valid[1] ? 1'b1 : rd.lru);  // empty way first
    assign serve      = (state == IDLE || state == FILL_DONE) && req.access;   // lookup allowed
    assign xfer_done  = drq && l2_rdy;
    assign miss_stall = (serve && !hit) || state == WRITEBACK || state == REFILL;

    always_comb begin
        state_n = state;
        case (state)
            IDLE, FILL_DONE: begin              // fill_done is the replay cycle
                state_n = IDLE;
                if (serve && !hit) begin
                    state_n = (rd.valid[victim_way] && rd.dirty[victim_way]) ? WRITEBACK : REFILL;
                end
            end
            WRITEBACK: if (xfer_done) state_n = REFILL;
            REFILL:    if (xfer_done) state_n = FILL_DONE;
            default:   state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            victim_q <= 1'b0;
            drq      <= 1'b0;
        end else begin
            state <= state_n;
            if (serve && !hit) begin
                victim_q <= victim_way;         // freeze choice for the whole miss
            end
            // drops for one cycle after each l2_rdy
            drq <= (state_n == WRITEBACK || state_n == REFILL) && !l2_rdy;
        end
    end

    // L2 side, all derived from held state
    assign l2_cache_rw = (state == WRITEBACK);
    assign l2_wr_line  = rd.line[victim_q];
    assign l2_addr     = (state == WRITEBACK)
                       ? {rd.tag[victim_q], req.addr.f.index, {OFF_W{1'b0}}}
                       : {req.addr.f.tag, req.addr.f.index, {OFF_W{1'b0}}};

    always_comb begin
        merged = hit_line;
        for (int b = 0; b < 4; b++) begin
            if (req.byte_en[b]) begin
                merged[req.addr.f.word_off * `WORD_W + b * 8 +: 8] = req.wr_data[b * 8 +: 8];
            end
        end
    end

    always_comb begin
        wr       = '0;
        wr.index = req.addr.f.index;
        wr.tag   = req.addr.f.tag;
        if (state == REFILL) begin
            wr.we    = xfer_done;               // line lands with l2_rdy
            wr.way   = victim_q;
            wr.line  = l2_rd_line;
            wr.valid = 1'b1;
            wr.dirty = 1'b0;                    // clean copy of L2
        end else if (serve && hit) begin
            wr.lru_we  = 1'b1;
            wr.lru_val = ~hit_way;              // other way becomes lru
            wr.we      = req.write;             // store hit merges in place
            wr.way     = hit_way;
            wr.line    = merged;
            wr.valid   = 1'b1;
            wr.dirty   = 1'b1;
        end
    end

    // L2 request is held steady until its ready pulse
    a_drq_stable : assert property (@(posedge clk) disable iff (!rst_n)
        drq && !l2_rdy |=> drq && $stable(l2_addr) && $stable(l2_cache_rw));

    // the refill must be visible in the RAM by the replay cycle
    a_replay_hit : assert property (@(posedge clk) disable iff (!rst_n)
        state == FILL_DONE && req.access |-> hit);

endmodule

//--- src/dcache_ram.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module dcache_ram import mem_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`INDEX_W-1:0] rd_index,
    input  dc_wr_t              wr,
    output dc_rd_t              rd
);

    logic [`TAG_W-1:0]        tag_mem  [2][`DC_SETS];   // per way
    logic [`LINE_W-1:0]       line_mem [2][`DC_SETS];
    logic [1:0][`DC_SETS-1:0] valid_q;
    logic [1:0][`DC_SETS-1:0] dirty_q;
    logic [`DC_SETS-1:0]      lru_q;                    // 1 -> way1 is lru

    // payload arrays, written at the edge
    always_ff @(posedge clk) begin
        if (wr.we) begin
            tag_mem[wr.way][wr.index]  <= wr.tag;
            line_mem[wr.way][wr.index] <= wr.line;
        end
    end

    // state bits, cleared by reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (wr.we) begin
                valid_q[wr.way][wr.index] <= wr.valid;
                dirty_q[wr.way][wr.index] <= wr.dirty;
            end
            if (wr.lru_we) begin
                lru_q[wr.index] <= wr.lru_val;
            end
        end
    end

    // asynchronous read port
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            rd.tag[w]   = tag_mem[w][rd_index];
            rd.line[w]  = line_mem[w][rd_index];
            rd.valid[w] = valid_q[w][rd_index];
            rd.dirty[w] = dirty_q[w][rd_index];
        end
        rd.lru = lru_q[rd_index];
    end

endmodule

//--- src/mem_ctrl.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem_ctrl import mem_pkg::*; (
    input  ex_mem_t             ex_in,      // from EX/MEM
    input  logic [`LINE_W-1:0]  hit_line,   // line of the hitting way
    output mem_req_t            req,        // to dcache_ctrl
    output logic [`WORD_W-1:0]  result,     // load data or ex_out
    output logic                miss_align
);

    dc_addr_u           addr;
    logic               is_ld;
    logic               is_st;
    logic               is_byte;
    logic               aligned;
    logic [`WORD_W-1:0] word_sel;
    logic [7:0]         byte_sel;

    assign addr.raw = ex_in.ex_out;                 // alu result is the address

    always_comb begin
        is_ld   = 1'b0;
        is_st   = 1'b0;
        is_byte = 1'b0;
        case (ex_in.mem_op)
            MEM_OP_LDW:  is_ld = 1'b1;
            MEM_OP_LDBU: begin
                is_ld   = 1'b1;
                is_byte = 1'b1;
            end
            MEM_OP_STW:  is_st = 1'b1;
            MEM_OP_STB: begin
                is_st   = 1'b1;
                is_byte = 1'b1;
            end
            default: ;                              // nop / non-memory op
        endcase
    end

    assign aligned    = is_byte || (addr.f.byte_off == 2'b00);  // bytes never misalign
    assign miss_align = ex_in.en && (is_ld || is_st) && !is_byte && |addr.f.byte_off;

    // cache request, bubbles and misaligned ops stay off the cache
    assign req.access  = ex_in.en && (is_ld || is_st) && aligned;
    assign req.write   = is_st;
    assign req.addr    = addr;
    assign req.byte_en = is_byte ? (4'b0001 << addr.f.byte_off) : 4'hf;
    assign req.wr_data = is_byte ? {4{ex_in.wr_data[7:0]}} : ex_in.wr_data;

    // load extraction, word 0 sits in the low bits of the line
    assign word_sel = hit_line[addr.f.word_off * `WORD_W +: `WORD_W];
    assign byte_sel = word_sel[addr.f.byte_off * 8 +: 8];

    always_comb begin
        if (miss_align) begin
            result = '0;                            // nothing written back anyway
        end else if (is_ld && is_byte) begin
            result = {{(`WORD_W-8){1'b0}}, byte_sel};   // zero extend
        end else if (is_ld) begin
            result = word_sel;
        end else begin
            result = ex_in.ex_out;                  // stores and alu ops
        end
    end

    // a misaligned op must never start a cache lookup or an L2 transfer
    always_comb begin
        assert (!(req.access && miss_align))
            else $error("mem_ctrl: cache access issued for misaligned op");
    end

endmodule

//--- src/mem_pkg.sv
`include "cpu_settings.svh"

package mem_pkg;

    // upper two bits zero -> no memory access
    typedef enum logic [3:0] {
        MEM_OP_NOP  = 4'b0000,
        MEM_OP_LDW  = 4'b0100,      // load word
        MEM_OP_LDBU = 4'b0101,      // load byte, zero extended
        MEM_OP_STW  = 4'b1000,      // store word
        MEM_OP_STB  = 4'b1001       // store byte
    } mem_op_e;

    typedef struct packed {
        logic [`TAG_W-1:0]   tag;
        logic [`INDEX_W-1:0] index;
        logic [1:0]          word_off;  // word within line
        logic [1:0]          byte_off;  // byte within word
    } dc_addr_t;

    typedef union packed {
        logic [`WORD_W-1:0] raw;        // plain byte address
        dc_addr_t           f;          // cache view
    } dc_addr_u;

    typedef struct packed {
        logic                   en;
        mem_op_e                mem_op;
        logic [`WORD_W-1:0]     wr_data;    // store source
        logic [`REG_ADDR_W-1:0] dst_addr;
        logic                   gpr_we_;    // active low
        logic [`WORD_W-1:0]     ex_out;     // alu result / address
    } ex_mem_t;

    typedef struct packed {
        logic               access;
        logic               write;
        dc_addr_u           addr;
        logic [`WORD_W-1:0] wr_data;        // replicated for byte stores
        logic [3:0]         byte_en;
    } mem_req_t;

    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] dst_addr;
        logic                   gpr_we_;
        logic [`WORD_W-1:0]     out;
        logic                   miss_align;
    } mem_wb_t;

    typedef struct packed {
        logic [1:0][`TAG_W-1:0]  tag;       // per way
        logic [1:0][`LINE_W-1:0] line;
        logic [1:0]              valid;
        logic [1:0]              dirty;
        logic                    lru;       // way to evict next
    } dc_rd_t;

    typedef struct packed {
        logic                we;            // tag/line/valid/dirty write
        logic                way;
        logic [`INDEX_W-1:0] index;
        logic [`TAG_W-1:0]   tag;
        logic [`LINE_W-1:0]  line;
        logic                valid;
        logic                dirty;
        logic                lru_we;
        logic                lru_val;
    } dc_wr_t;

endpackage

//--- src/mem_reg.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem_reg import mem_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,       // hazard unit
    input  logic               miss_stall,  // cache miss in progress
    input  logic               flush,
    input  ex_mem_t            ex_in,
    input  logic [`WORD_W-1:0] result,
    input  logic               miss_align,
    output mem_wb_t            wb_out
);

    logic                   en_q;
    logic                   gpr_we_q;       // active low
    logic                   align_q;
    logic [`REG_ADDR_W-1:0] dst_q;
    logic [`WORD_W-1:0]     out_q;
    logic                   hold;

    assign hold = stall || miss_stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en_q     <= 1'b0;
            gpr_we_q <= 1'b1;
            align_q  <= 1'b0;
        end else if (!hold) begin
            if (flush) begin                    // bubble into WB
                en_q     <= 1'b0;
                gpr_we_q <= 1'b1;
                align_q  <= 1'b0;
            end else begin
                en_q     <= ex_in.en;
                gpr_we_q <= ex_in.gpr_we_ | miss_align;     // no gpr write on misalign
                align_q  <= miss_align;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            dst_q <= ex_in.dst_addr;
            out_q <= result;
        end
    end

    assign wb_out = '{en: en_q, dst_addr: dst_q, gpr_we_: gpr_we_q, out: out_q,
                      miss_align: align_q};

    // flush outside any stall empties the MEM/WB slot
    a_flush_bubble : assert property (@(posedge clk) disable iff (!rst_n)
        flush && !stall && !miss_stall |=> !wb_out.en);

endmodule

//--- src/mem_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem_stage import mem_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,           // from hazard unit
    input  logic               flush,
    input  ex_mem_t            ex_in,           // EX/MEM register
    output logic [`WORD_W-1:0] fwd_data,        // to forwarding network
    output logic               miss_stall,      // to hazard unit
    output mem_wb_t            wb_out,          // MEM/WB register
    output logic               drq,             // L2 request
    output logic               l2_cache_rw,     // 1 = write
    output logic [`WORD_W-1:0] l2_addr,         // line address
    output logic [`LINE_W-1:0] l2_wr_line,
    input  logic [`LINE_W-1:0] l2_rd_line,
    input  logic               l2_rdy
);

    mem_req_t            req;
    logic [`LINE_W-1:0]  hit_line;
    logic [`WORD_W-1:0]  result;
    logic                miss_align;
    logic [`INDEX_W-1:0] rd_index;
    dc_rd_t              rd;
    dc_wr_t              wr;

    assign fwd_data = result;                   // same-cycle forward

    mem_ctrl u_mem_ctrl (
        .ex_in      (ex_in),
        .hit_line   (hit_line),
        .req        (req),
        .result     (result),
        .miss_align (miss_align)
    );

    dcache_ctrl u_dcache_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .rd          (rd),
        .l2_rd_line  (l2_rd_line),
        .l2_rdy      (l2_rdy),
        .rd_index    (rd_index),
        .wr          (wr),
        .hit_line    (hit_line),
        .miss_stall  (miss_stall),
        .drq         (drq),
        .l2_cache_rw (l2_cache_rw),
        .l2_addr     (l2_addr),
        .l2_wr_line  (l2_wr_line)
    );

    dcache_ram u_dcache_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_index (rd_index),
        .wr       (wr),
        .rd       (rd)
    );

    mem_reg u_mem_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .miss_stall (miss_stall),
        .flush      (flush),
        .ex_in      (ex_in),
        .result     (result),
        .miss_align (miss_align),
        .wb_out     (wb_out)
    );

endmodule
